/* verilog/ntm_pkg.sv */
// FSM state encodings shared by the collector, the scalar multiplier and the testbench; no timing or width parameters live here
package ntm_pkg;

  //////////////////////////////////////////////////////////////////////
  // Operand collector states
  //////////////////////////////////////////////////////////////////////

  // Idle waits for START
  // Collect gathers A and B strobes
  // Push hands the finished pair to the queue
  typedef enum logic [1:0] {
    COLLECTOR_IDLE    = 2'd0,
    COLLECTOR_COLLECT = 2'd1,
    COLLECTOR_PUSH    = 2'd2
  } collector_state_t;

  //////////////////////////////////////////////////////////////////////
  // Scalar multiplier states
  //////////////////////////////////////////////////////////////////////

  // Idle pops a pair when the queue has one
  // Load clears the accumulator and the bit counter
  // Iterate runs one shift-add-reduce step per bit of b
  // Emit holds DATA_OUT_ENABLE for its single cycle
  typedef enum logic [1:0] {
    MULTIPLIER_IDLE    = 2'd0,
    MULTIPLIER_LOAD    = 2'd1,
    MULTIPLIER_ITERATE = 2'd2,
    MULTIPLIER_EMIT    = 2'd3
  } multiplier_state_t;

  // All four 2-bit codes are used by the multiplier
  // The collector leaves code 3 unused and recovers to idle from it

endpackage

/* verilog/ntm_pair_if.sv */
// Push and pop sides of the pair queue; push while full is dropped and pop is only legal while empty is low
`timescale 1ns/1ns

interface ntm_pair_if #(
  parameter type PAIR_T = logic
);

  // Producer side
  logic  push;
  PAIR_T pair;
  logic  full;

  // Consumer side
  // Head valid whenever empty is low
  PAIR_T head;
  logic  empty;
  logic  pop;

  // Operand collector
  modport producer (output push, output pair, input full);

  // Queue write side
  modport store_in (input push, input pair, output full);

  // Queue read side
  modport store_out (output head, output empty, input pop);

  // Scalar multiplier
  modport consumer (input head, input empty, output pop);

endinterface

/* verilog/ntm_operand_collector.sv */
// Needs SIZE_IN of at least 1 and CONTROL_SIZE no wider than DATA_SIZE; pairs finished while the queue is full are lost
`timescale 1ns/1ns

module ntm_operand_collector #(
  parameter int DATA_SIZE    = 16,
  parameter int CONTROL_SIZE = 8
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 START,
  input  logic                 DATA_A_IN_ENABLE,
  input  logic                 DATA_B_IN_ENABLE,
  input  logic [DATA_SIZE-1:0] MODULO_IN,
  input  logic [DATA_SIZE-1:0] SIZE_IN,
  input  logic [DATA_SIZE-1:0] DATA_A_IN,
  input  logic [DATA_SIZE-1:0] DATA_B_IN,
  ntm_pair_if.producer         push_bus
);

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  ntm_pkg::collector_state_t state;

  // Element position inside the current vector
  logic [CONTROL_SIZE-1:0] index;
  logic [CONTROL_SIZE-1:0] last_index;

  // Operand hold flags and their registers
  logic                 a_held;
  logic                 b_held;
  logic [DATA_SIZE-1:0] a_reg;
  logic [DATA_SIZE-1:0] b_reg;

  logic a_held_next;
  logic b_held_next;
  logic is_last;

  //////////////////////////////////////////////////////////////////////
  // Pairing
  //////////////////////////////////////////////////////////////////////

  // Flags restart after a push, so strobes in the push cycle open the next pair
  always_comb begin
    a_held_next = ((state == ntm_pkg::COLLECTOR_PUSH) ? 1'b0 : a_held) | DATA_A_IN_ENABLE;
    b_held_next = ((state == ntm_pkg::COLLECTOR_PUSH) ? 1'b0 : b_held) | DATA_B_IN_ENABLE;
  end

  assign is_last = (index == last_index);

  // Pair layout follows the top-level struct: a, b, modulo, last
  // Modulo is sampled in the push cycle itself
  assign push_bus.push = (state == ntm_pkg::COLLECTOR_PUSH);
  assign push_bus.pair = {a_reg, b_reg, MODULO_IN, is_last};

  //////////////////////////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state      <= ntm_pkg::COLLECTOR_IDLE;
      index      <= '0;
      last_index <= '0;
      a_held     <= 1'b0;
      b_held     <= 1'b0;
    end else begin
      case (state)
        ntm_pkg::COLLECTOR_IDLE: begin
          // START only counts here
          if (START) begin
            last_index <= SIZE_IN[CONTROL_SIZE-1:0] - 1'b1;
            index      <= '0;
            a_held     <= 1'b0;
            b_held     <= 1'b0;
            state      <= ntm_pkg::COLLECTOR_COLLECT;
          end
        end
        ntm_pkg::COLLECTOR_COLLECT: begin
          a_held <= a_held_next;
          b_held <= b_held_next;
          if (a_held_next && b_held_next) begin
            state <= ntm_pkg::COLLECTOR_PUSH;
          end
        end
        ntm_pkg::COLLECTOR_PUSH: begin
          if (is_last) begin
            // Vector complete
            a_held <= 1'b0;
            b_held <= 1'b0;
            state  <= ntm_pkg::COLLECTOR_IDLE;
          end else begin
            index  <= index + 1'b1;
            a_held <= a_held_next;
            b_held <= b_held_next;
            // Both operands of the next pair may already be here
            if (a_held_next && b_held_next) begin
              state <= ntm_pkg::COLLECTOR_PUSH;
            end else begin
              state <= ntm_pkg::COLLECTOR_COLLECT;
            end
          end
        end
        default: begin
          state <= ntm_pkg::COLLECTOR_IDLE;
        end
      endcase
    end
  end

  // Operand capture, only while a vector is open
  always_ff @(posedge CLK) begin
    if (state != ntm_pkg::COLLECTOR_IDLE && DATA_A_IN_ENABLE) begin
      a_reg <= DATA_A_IN;
    end
    if (state != ntm_pkg::COLLECTOR_IDLE && DATA_B_IN_ENABLE) begin
      b_reg <= DATA_B_IN;
    end
  end

endmodule

/* verilog/ntm_pair_fifo.sv */
// First-word-fall-through queue; FIFO_DEPTH must be a power of two of at least 2, pushes while full are dropped
`timescale 1ns/1ns

module ntm_pair_fifo #(
  parameter int  FIFO_DEPTH = 4,
  parameter type PAIR_T     = logic
) (
  input  logic          CLK,
  input  logic          RST,
  ntm_pair_if.store_in  in_bus,
  ntm_pair_if.store_out out_bus
);

  localparam int PTR_SIZE = $clog2(FIFO_DEPTH);

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  // Storage array
  PAIR_T mem [FIFO_DEPTH];

  // Pointers wrap on their own width
  logic [PTR_SIZE-1:0] wr_ptr;
  logic [PTR_SIZE-1:0] rd_ptr;
  logic [PTR_SIZE:0]   count;

  logic do_push;
  logic do_pop;

  //////////////////////////////////////////////////////////////////////
  // Status and head
  //////////////////////////////////////////////////////////////////////

  assign in_bus.full   = (count == (PTR_SIZE+1)'(FIFO_DEPTH));
  assign out_bus.empty = (count == '0);

  // Head falls through as soon as the entry is written
  assign out_bus.head = mem[rd_ptr];

  // Qualified requests
  assign do_push = in_bus.push && !in_bus.full;
  assign do_pop  = out_bus.pop && !out_bus.empty;

  //////////////////////////////////////////////////////////////////////
  // Pointers and occupancy
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Push and pop together leave count alone
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Entry write
  always_ff @(posedge CLK) begin
    if (do_push) begin
      mem[wr_ptr] <= in_bus.pair;
    end
  end

endmodule

/* verilog/ntm_scalar_multiplier.sv */
// Operands must be below a nonzero modulo; one result per DATA_SIZE+3 cycles, head layout is a, b, modulo, last
`timescale 1ns/1ns

module ntm_scalar_multiplier #(
  parameter int DATA_SIZE = 16
) (
  input  logic                 CLK,
  input  logic                 RST,
  ntm_pair_if.consumer         pop_bus,
  output logic [DATA_SIZE-1:0] DATA_OUT,
  output logic                 DATA_OUT_ENABLE,
  output logic                 READY
);

  localparam int COUNT_SIZE = (DATA_SIZE > 1) ? $clog2(DATA_SIZE) : 1;
  localparam int PAIR_SIZE  = 3*DATA_SIZE + 1;

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  ntm_pkg::multiplier_state_t state;

  // Flat view of the queue head
  logic [PAIR_SIZE-1:0] head_bits;

  // Operands of the pair in flight
  logic [DATA_SIZE-1:0] a_reg;
  logic [DATA_SIZE-1:0] b_reg;
  logic [DATA_SIZE-1:0] modulo_reg;
  logic                 last_reg;

  // Running remainder and scan position in b
  logic [DATA_SIZE-1:0]  acc;
  logic [COUNT_SIZE-1:0] bit_index;

  // Two guard bits cover 2*acc + a < 3*modulo
  logic [DATA_SIZE+1:0] modulo_ext;
  logic [DATA_SIZE+1:0] doubled;
  logic [DATA_SIZE+1:0] summed;
  logic [DATA_SIZE+1:0] reduced_once;
  logic [DATA_SIZE+1:0] reduced;

  //////////////////////////////////////////////////////////////////////
  // Queue side
  //////////////////////////////////////////////////////////////////////

  assign head_bits = pop_bus.head;

  // Pop in the idle cycle that sees a valid head
  assign pop_bus.pop = (state == ntm_pkg::MULTIPLIER_IDLE) && !pop_bus.empty;

  //////////////////////////////////////////////////////////////////////
  // Interleaved modular step
  //////////////////////////////////////////////////////////////////////

  // acc = (2*acc + b[i]*a) mod m, MSB of b first
  always_comb begin
    modulo_ext   = {2'b00, modulo_reg};
    doubled      = {1'b0, acc, 1'b0};
    summed       = doubled + (b_reg[bit_index] ? {2'b00, a_reg} : '0);
    reduced_once = (summed >= modulo_ext) ? summed - modulo_ext : summed;
    reduced      = (reduced_once >= modulo_ext) ? reduced_once - modulo_ext : reduced_once;
  end

  //////////////////////////////////////////////////////////////////////
  // Control FSM and outputs
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state           <= ntm_pkg::MULTIPLIER_IDLE;
      DATA_OUT        <= '0;
      DATA_OUT_ENABLE <= 1'b0;
      READY           <= 1'b0;
    end else begin
      case (state)
        ntm_pkg::MULTIPLIER_IDLE: begin
          if (!pop_bus.empty) begin
            state <= ntm_pkg::MULTIPLIER_LOAD;
          end
        end
        ntm_pkg::MULTIPLIER_LOAD: begin
          state <= ntm_pkg::MULTIPLIER_ITERATE;
        end
        ntm_pkg::MULTIPLIER_ITERATE: begin
          // Final bit; result and strobes land in the emit cycle
          if (bit_index == '0) begin
            DATA_OUT        <= reduced[DATA_SIZE-1:0];
            DATA_OUT_ENABLE <= 1'b1;
            READY           <= last_reg;
            state           <= ntm_pkg::MULTIPLIER_EMIT;
          end
        end
        ntm_pkg::MULTIPLIER_EMIT: begin
          DATA_OUT_ENABLE <= 1'b0;
          READY           <= 1'b0;
          state           <= ntm_pkg::MULTIPLIER_IDLE;
        end
        default: begin
          state <= ntm_pkg::MULTIPLIER_IDLE;
        end
      endcase
    end
  end

  // Datapath
  always_ff @(posedge CLK) begin
    if (pop_bus.pop) begin
      {a_reg, b_reg, modulo_reg, last_reg} <= head_bits;
    end
    if (state == ntm_pkg::MULTIPLIER_LOAD) begin
      acc       <= '0;
      bit_index <= COUNT_SIZE'(DATA_SIZE - 1);
    end else if (state == ntm_pkg::MULTIPLIER_ITERATE) begin
      acc       <= reduced[DATA_SIZE-1:0];
      bit_index <= bit_index - 1'b1;
    end
  end

endmodule

/* verilog/ntm_vector_multiplier.sv */
// Plain strobes without handshake; keep at most FIFO_DEPTH pairs ahead of the results, operands below nonzero MODULO_IN
`timescale 1ns/1ns

module ntm_vector_multiplier #(
  parameter int DATA_SIZE    = 16,
  parameter int CONTROL_SIZE = 8,
  parameter int FIFO_DEPTH   = 4
) (
  // Global
  input  logic                 CLK,
  input  logic                 RST,

  // Control
  input  logic                 START,
  output logic                 READY,
  input  logic                 DATA_A_IN_ENABLE,
  input  logic                 DATA_B_IN_ENABLE,
  output logic                 DATA_OUT_ENABLE,

  // Data
  input  logic [DATA_SIZE-1:0] MODULO_IN,
  input  logic [DATA_SIZE-1:0] SIZE_IN,
  input  logic [DATA_SIZE-1:0] DATA_A_IN,
  input  logic [DATA_SIZE-1:0] DATA_B_IN,
  output logic [DATA_SIZE-1:0] DATA_OUT
);

  //////////////////////////////////////////////////////////////////////
  // Queue payload
  //////////////////////////////////////////////////////////////////////

  // Field order is relied on by collector and multiplier
  typedef struct packed {
    logic [DATA_SIZE-1:0] a;
    logic [DATA_SIZE-1:0] b;
    logic [DATA_SIZE-1:0] modulo;
    logic                 last;
  } operand_pair_t;

  // Collector to queue, queue to multiplier
  ntm_pair_if #(.PAIR_T(operand_pair_t)) push_bus ();
  ntm_pair_if #(.PAIR_T(operand_pair_t)) pop_bus ();

  //////////////////////////////////////////////////////////////////////
  // Blocks
  //////////////////////////////////////////////////////////////////////

  ntm_operand_collector #(
    .DATA_SIZE   (DATA_SIZE),
    .CONTROL_SIZE(CONTROL_SIZE)
  ) operand_collector (
    .CLK             (CLK),
    .RST             (RST),
    .START           (START),
    .DATA_A_IN_ENABLE(DATA_A_IN_ENABLE),
    .DATA_B_IN_ENABLE(DATA_B_IN_ENABLE),
    .MODULO_IN       (MODULO_IN),
    .SIZE_IN         (SIZE_IN),
    .DATA_A_IN       (DATA_A_IN),
    .DATA_B_IN       (DATA_B_IN),
    .push_bus        (push_bus.producer)
  );

  ntm_pair_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH),
    .PAIR_T    (operand_pair_t)
  ) pair_fifo (
    .CLK    (CLK),
    .RST    (RST),
    .in_bus (push_bus.store_in),
    .out_bus(pop_bus.store_out)
  );

  ntm_scalar_multiplier #(
    .DATA_SIZE(DATA_SIZE)
  ) scalar_multiplier (
    .CLK            (CLK),
    .RST            (RST),
    .pop_bus        (pop_bus.consumer),
    .DATA_OUT       (DATA_OUT),
    .DATA_OUT_ENABLE(DATA_OUT_ENABLE),
    .READY          (READY)
  );

endmodule

/* verification/ntm_vector_multiplier_tb.sv */
// Default DUT parameters only; keeps at most FIFO_DEPTH pairs outstanding, so no overflow
`timescale 1ns/1ns

module ntm_vector_multiplier_tb;

  localparam int DATA_SIZE      = 16;
  localparam int FIFO_DEPTH     = 4;
  localparam int NUM_RANDOM_VEC = 8;
  // Six directed pairs plus the random vector sizes below
  localparam int TOTAL_ELEMENTS = 43;
  localparam int WATCHDOG_CYCLES = TOTAL_ELEMENTS * (DATA_SIZE + 10) + 400;

  //////////////////////////////////////////////////////////////////////
  // DUT signals
  //////////////////////////////////////////////////////////////////////

  logic                 CLK;
  logic                 RST;
  logic                 START;
  logic                 READY;
  logic                 DATA_A_IN_ENABLE;
  logic                 DATA_B_IN_ENABLE;
  logic                 DATA_OUT_ENABLE;
  logic [DATA_SIZE-1:0] MODULO_IN;
  logic [DATA_SIZE-1:0] SIZE_IN;
  logic [DATA_SIZE-1:0] DATA_A_IN;
  logic [DATA_SIZE-1:0] DATA_B_IN;
  logic [DATA_SIZE-1:0] DATA_OUT;

  // Reference model, one entry per pair sent
  logic [DATA_SIZE-1:0] exp_data [$];
  logic                 exp_last [$];
  logic [DATA_SIZE-1:0] exp_value;
  logic                 exp_flag;

  integer seed;
  int     errors;
  int     results;
  int     pushed;
  logic   seen_result;

  // Directed edge cases: modulo one, zero operands, modulo minus one
  logic [DATA_SIZE-1:0] edge_a [6] = '{16'h0000, 16'h0000, 16'h8000, 16'hfffe, 16'h000c, 16'h7fff};
  logic [DATA_SIZE-1:0] edge_b [6] = '{16'h0000, 16'h1234, 16'h0000, 16'hfffe, 16'h0003, 16'h0003};
  logic [DATA_SIZE-1:0] edge_m [6] = '{16'h0001, 16'h8001, 16'h8001, 16'hffff, 16'h000d, 16'h8000};
  int                   vec_size [NUM_RANDOM_VEC] = '{1, 1, 3, 5, 1, 8, 2, 16};

  ntm_vector_multiplier DUT (
    .CLK             (CLK),
    .RST             (RST),
    .START           (START),
    .READY           (READY),
    .DATA_A_IN_ENABLE(DATA_A_IN_ENABLE),
    .DATA_B_IN_ENABLE(DATA_B_IN_ENABLE),
    .DATA_OUT_ENABLE (DATA_OUT_ENABLE),
    .MODULO_IN       (MODULO_IN),
    .SIZE_IN         (SIZE_IN),
    .DATA_A_IN       (DATA_A_IN),
    .DATA_B_IN       (DATA_B_IN),
    .DATA_OUT        (DATA_OUT)
  );

  // 8 ns period
  always #4 CLK = ~CLK;

  //////////////////////////////////////////////////////////////////////
  // Stimulus tasks, entered on a falling edge
  //////////////////////////////////////////////////////////////////////

  task automatic start_vector(input int size);
    START   = 1'b1;
    SIZE_IN = DATA_SIZE'(size);
    @(negedge CLK);
    START   = 1'b0;
  endtask

  // Order 0 sends A first, 1 sends B first, 2 sends both together
  task automatic send_pair(input logic [DATA_SIZE-1:0] a, input logic [DATA_SIZE-1:0] b,
                           input logic [DATA_SIZE-1:0] m, input int order, input logic last);
    logic [63:0] product;
    // Wait for room so no pair is dropped
    while (exp_data.size() >= FIFO_DEPTH) begin
      @(negedge CLK);
    end
    product = (64'(a) * 64'(b)) % 64'(m);
    exp_data.push_back(product[DATA_SIZE-1:0]);
    exp_last.push_back(last);
    pushed++;
    MODULO_IN = m;
    // Unstrobed data bus carries a decoy value
    case (order)
      0: begin
        DATA_A_IN        = a;
        DATA_B_IN        = ~b;
        DATA_A_IN_ENABLE = 1'b1;
        @(negedge CLK);
        DATA_A_IN        = ~a;
        DATA_B_IN        = b;
        DATA_A_IN_ENABLE = 1'b0;
        DATA_B_IN_ENABLE = 1'b1;
      end
      1: begin
        DATA_A_IN        = ~a;
        DATA_B_IN        = b;
        DATA_B_IN_ENABLE = 1'b1;
        @(negedge CLK);
        DATA_A_IN        = a;
        DATA_B_IN        = ~b;
        DATA_B_IN_ENABLE = 1'b0;
        DATA_A_IN_ENABLE = 1'b1;
      end
      default: begin
        DATA_A_IN        = a;
        DATA_B_IN        = b;
        DATA_A_IN_ENABLE = 1'b1;
        DATA_B_IN_ENABLE = 1'b1;
      end
    endcase
    @(negedge CLK);
    // Push cycle, modulo still held
    DATA_A_IN_ENABLE = 1'b0;
    DATA_B_IN_ENABLE = 1'b0;
    @(negedge CLK);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  ready_with_result: assert property (@(posedge CLK) disable iff (RST)
    READY |-> DATA_OUT_ENABLE)
    else begin
      errors++;
      $display("READY was high without a result pulse");
    end

  single_cycle_pulse: assert property (@(posedge CLK) disable iff (RST)
    DATA_OUT_ENABLE |=> !DATA_OUT_ENABLE)
    else begin
      errors++;
      $display("DATA_OUT_ENABLE stayed high for more than one cycle");
    end

  // Results in order against the reference queue
  always @(posedge CLK) begin
    if (!RST) begin
      if (DATA_OUT_ENABLE) begin
        seen_result = 1'b1;
        assert (exp_data.size() != 0)
          else begin
            errors++;
            $display("result pulse arrived with no pair outstanding");
          end
        if (exp_data.size() != 0) begin
          exp_value = exp_data.pop_front();
          exp_flag  = exp_last.pop_front();
          results++;
          assert (DATA_OUT == exp_value)
            else begin
              errors++;
              $display("mismatch DATA_OUT: expected 0x%h, got 0x%h", exp_value, DATA_OUT);
            end
          assert (READY == exp_flag)
            else begin
              errors++;
              $display("mismatch READY: expected 0x%h, got 0x%h", exp_flag, READY);
            end
        end
      end else if (!seen_result) begin
        // Quiet outputs before the first result
        assert (DATA_OUT == '0)
          else begin
            errors++;
            $display("mismatch DATA_OUT: expected 0x%h, got 0x%h", {DATA_SIZE{1'b0}}, DATA_OUT);
          end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    $display("timeout: results still missing after %0d cycles", WATCHDOG_CYCLES);
    $display("STATUS: FAIL");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0]          r;
    logic [DATA_SIZE-1:0] m;
    logic [DATA_SIZE-1:0] a;
    logic [DATA_SIZE-1:0] b;
    int                   order_sel;
    seed             = 32'heae3;
    errors           = 0;
    results          = 0;
    pushed           = 0;
    seen_result      = 1'b0;
    order_sel        = 0;
    CLK              = 1'b0;
    RST              = 1'b1;
    START            = 1'b0;
    DATA_A_IN_ENABLE = 1'b0;
    DATA_B_IN_ENABLE = 1'b0;
    MODULO_IN        = 16'h0001;
    SIZE_IN          = 16'h0001;
    DATA_A_IN        = '0;
    DATA_B_IN        = '0;
    repeat (4) @(negedge CLK);
    RST = 1'b0;
    @(negedge CLK);

    // Directed edge cases, all three strobe orders
    start_vector(6);
    for (int i = 0; i < 6; i++) begin
      send_pair(edge_a[i], edge_b[i], edge_m[i], i % 3, i == 5);
    end

    // Random vectors back to back, modulo changing per pair
    for (int v = 0; v < NUM_RANDOM_VEC; v++) begin
      start_vector(vec_size[v]);
      for (int i = 0; i < vec_size[v]; i++) begin
        r = $random(seed);
        m = r[DATA_SIZE-1:0];
        if (m == '0) begin
          m = 16'h0001;
        end
        r = $random(seed);
        a = r[DATA_SIZE-1:0] % m;
        r = $random(seed);
        b = r[DATA_SIZE-1:0] % m;
        send_pair(a, b, m, order_sel % 3, i == vec_size[v] - 1);
        order_sel++;
      end
    end

    // Drain outstanding results
    while (exp_data.size() != 0) begin
      @(negedge CLK);
    end
    // One more result time, so a stray pulse is still caught
    repeat (DATA_SIZE + 4) @(negedge CLK);

    $display("errors: %0d, results checked: %0d of %0d", errors, results, pushed);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* list.f */
verilog/ntm_pkg.sv
verilog/ntm_pair_if.sv
verilog/ntm_operand_collector.sv
verilog/ntm_pair_fifo.sv
verilog/ntm_scalar_multiplier.sv
verilog/ntm_vector_multiplier.sv
verification/ntm_vector_multiplier_tb.sv

/* Bender.yml */
package:
  name: ntm_vector_multiplier

sources:
  # Package first, then interface, blocks and top level
  - files:
      - verilog/ntm_pkg.sv
      - verilog/ntm_pair_if.sv
      - verilog/ntm_operand_collector.sv
      - verilog/ntm_pair_fifo.sv
      - verilog/ntm_scalar_multiplier.sv
      - verilog/ntm_vector_multiplier.sv

  # Testbench
  - target: test
    files:
      - verification/ntm_vector_multiplier_tb.sv
